// ==== rtl/alu_pkg.sv ====
package alu_pkg;

  // op[3:2] picks the group, op[1:0] the op inside it
  typedef enum logic [3:0] {
    OP_OR    = 4'h0,
    OP_AND   = 4'h1,
    OP_SAL   = 4'h2,
    OP_SAR   = 4'h3,
    OP_PASS1 = 4'h4,
    OP_PASS2 = 4'h5,
    OP_CLR   = 4'h6,
    OP_NOT   = 4'h7,
    OP_INC   = 4'h8,
    OP_ADD   = 4'h9,
    OP_STEP  = 4'ha,
    OP_CMP   = 4'hb,
    OP_DAA   = 4'hc
  } alu_op_e;

  localparam logic [1:0] GRP_LOGIC = 2'd0;
  localparam logic [1:0] GRP_MOVE  = 2'd1;
  localparam logic [1:0] GRP_ARITH = 2'd2;
  localparam logic [1:0] GRP_DAA   = 2'd3;

  typedef enum logic [1:0] {
    SZ_8  = 2'd0,
    SZ_16 = 2'd1,
    SZ_32 = 2'd2
  } op_size_e;

  localparam int unsigned FLAG_CF = 0;
  localparam int unsigned FLAG_PF = 1;
  localparam int unsigned FLAG_AF = 2;
  localparam int unsigned FLAG_ZF = 3;
  localparam int unsigned FLAG_SF = 4;
  localparam int unsigned FLAG_OF = 5;

  typedef struct packed {
    alu_op_e     op;
    op_size_e    size;
    op_size_e    elem_size;
    logic [31:0] sr1;
    logic [31:0] sr2;
    logic [31:0] eax;
    logic [5:0]  ld_flags;
  } uop_t;

  typedef struct packed {
    logic [31:0] result;
    logic [5:0]  flags;
  } res_t;

  // cf lands on bit 0, df on bit 6
  typedef struct packed {
    logic df;
    logic of;
    logic sf;
    logic zf;
    logic af;
    logic pf;
    logic cf;
  } flags_t;

  localparam int CSR_AW = 4;
  localparam logic [CSR_AW-1:0] CSR_CTRL  = 4'h0;
  localparam logic [CSR_AW-1:0] CSR_FLAGS = 4'h4;
  localparam logic [CSR_AW-1:0] CSR_COUNT = 4'h8;

endpackage

// ==== rtl/alu1.sv ====
`timescale 1ns/1ns

module alu1 (
  input  alu_pkg::uop_t   uop,
  input  alu_pkg::flags_t cur_flags,
  output alu_pkg::res_t   res,
  output logic [5:0]      ld_mask
);

  function automatic logic [31:0] size_mask(alu_pkg::op_size_e s);
    case (s)
      alu_pkg::SZ_8:  return 32'h0000_00ff;
      alu_pkg::SZ_16: return 32'h0000_ffff;
      default:        return 32'hffff_ffff;
    endcase
  endfunction

  function automatic logic top_bit(logic [31:0] v, alu_pkg::op_size_e s);
    case (s)
      alu_pkg::SZ_8:  return v[7];
      alu_pkg::SZ_16: return v[15];
      default:        return v[31];
    endcase
  endfunction

  // ZF, SF and PF follow the result at operand size
  function automatic logic [5:0] mk_flags(logic [31:0] r, alu_pkg::op_size_e s,
                                           logic cf, logic af, logic of);
    logic [5:0] f;
    f = '0;
    f[alu_pkg::FLAG_CF] = cf;
    f[alu_pkg::FLAG_PF] = ~^r[7:0];
    f[alu_pkg::FLAG_AF] = af;
    f[alu_pkg::FLAG_ZF] = (r & size_mask(s)) == 32'd0;
    f[alu_pkg::FLAG_SF] = top_bit(r, s);
    f[alu_pkg::FLAG_OF] = of;
    return f;
  endfunction

  // Subtract is a + ~b + 1, CF and AF then read as borrows
  function automatic alu_pkg::res_t add_sub(logic [31:0] a, logic [31:0] b, logic sub,
                                            alu_pkg::op_size_e s);
    logic [31:0]   bb;
    logic [32:0]   sum;
    logic [32:0]   cy;
    logic          c_out;
    logic          c_msb;
    alu_pkg::res_t r;
    bb  = sub ? ~b : b;
    sum = {1'b0, a} + {1'b0, bb} + 33'(sub);
    // Carry into each bit position
    cy  = sum ^ {1'b0, a} ^ {1'b0, bb};
    case (s)
      alu_pkg::SZ_8: begin
        c_out = cy[8];
        c_msb = cy[7];
      end
      alu_pkg::SZ_16: begin
        c_out = cy[16];
        c_msb = cy[15];
      end
      default: begin
        c_out = cy[32];
        c_msb = cy[31];
      end
    endcase
    r.result = sum[31:0];
    r.flags  = mk_flags(sum[31:0], s, c_out ^ sub, cy[4] ^ sub, c_out ^ c_msb);
    return r;
  endfunction

  logic [4:0]    cnt;
  logic [31:0]   opnd;
  logic [31:0]   opnd_sx;
  logic [63:0]   sal_full;
  logic [32:0]   sar_full;
  logic          sal_cf;
  logic [31:0]   step;
  logic [7:0]    al;
  logic          adj_lo;
  logic          adj_hi;
  logic [7:0]    al_adj;
  logic [31:0]   logic_v;
  logic          logic_cf;
  logic          logic_of;
  logic [31:0]   move_v;
  alu_pkg::res_t inc_r;
  alu_pkg::res_t add_r;
  alu_pkg::res_t cmp_r;
  alu_pkg::res_t logic_r;
  alu_pkg::res_t move_r;
  alu_pkg::res_t arith_r;
  alu_pkg::res_t daa_r;

  assign cnt  = uop.sr2[4:0];
  assign opnd = uop.sr1 & size_mask(uop.size);

  always_comb begin
    case (uop.size)
      alu_pkg::SZ_8:  opnd_sx = {{24{uop.sr1[7]}}, uop.sr1[7:0]};
      alu_pkg::SZ_16: opnd_sx = {{16{uop.sr1[15]}}, uop.sr1[15:0]};
      default:        opnd_sx = uop.sr1;
    endcase
  end

  // Last bit out of SAL sits just above the operand size
  assign sal_full = {32'd0, opnd} << cnt;
  assign sar_full = 33'($signed({opnd_sx, 1'b0}) >>> cnt);

  always_comb begin
    case (uop.size)
      alu_pkg::SZ_8:  sal_cf = sal_full[8];
      alu_pkg::SZ_16: sal_cf = sal_full[16];
      default:        sal_cf = sal_full[32];
    endcase
  end

  assign inc_r = add_sub(uop.sr1, 32'd1, 1'b0, uop.size);
  assign add_r = add_sub(uop.sr1, uop.sr2, 1'b0, uop.size);
  assign cmp_r = add_sub(uop.eax, uop.sr1, 1'b1, uop.size);

  // String pointer step by element size
  always_comb begin
    case (uop.elem_size)
      alu_pkg::SZ_8:  step = 32'd1;
      alu_pkg::SZ_16: step = 32'd2;
      default:        step = 32'd4;
    endcase
    if (cur_flags.df) begin
      step = -step;
    end
  end

  // Decimal adjust of AL
  assign al     = uop.eax[7:0];
  assign adj_lo = (al[3:0] > 4'h9) || cur_flags.af;
  assign adj_hi = (al > 8'h99) || cur_flags.cf;
  assign al_adj = al + {(adj_hi ? 4'h6 : 4'h0), (adj_lo ? 4'h6 : 4'h0)};

  always_comb begin
    case (uop.op[1:0])
      2'd0: begin
        logic_v  = uop.sr1 | uop.sr2;
        logic_cf = 1'b0;
        logic_of = 1'b0;
      end
      2'd1: begin
        logic_v  = uop.sr1 & uop.sr2;
        logic_cf = 1'b0;
        logic_of = 1'b0;
      end
      2'd2: begin
        logic_v  = sal_full[31:0];
        logic_cf = sal_cf;
        logic_of = top_bit(sal_full[31:0], uop.size) ^ sal_cf;
      end
      default: begin
        logic_v  = sar_full[32:1];
        logic_cf = sar_full[0];
        logic_of = 1'b0;
      end
    endcase
    logic_r.result = logic_v;
    logic_r.flags  = mk_flags(logic_v, uop.size, logic_cf, 1'b0, logic_of);

    case (uop.op[1:0])
      2'd0:    move_v = uop.sr1;
      2'd1:    move_v = uop.sr2;
      2'd2:    move_v = 32'd0;
      default: move_v = ~uop.sr1;
    endcase
    move_r.result = move_v;
    move_r.flags  = mk_flags(move_v, uop.size, 1'b0, 1'b0, 1'b0);

    case (uop.op[1:0])
      2'd0: arith_r = inc_r;
      2'd1: arith_r = add_r;
      2'd2: begin
        arith_r.result = uop.sr1 + step;
        arith_r.flags  = 6'd0;
      end
      default: begin
        // CMP keeps sr1 on the result, only its flags count
        arith_r.result = uop.sr1;
        arith_r.flags  = cmp_r.flags;
      end
    endcase

    daa_r.result = {uop.eax[31:8], al_adj};
    daa_r.flags  = mk_flags({24'd0, al_adj}, alu_pkg::SZ_8, adj_hi, adj_lo, 1'b0);

    case (uop.op[3:2])
      alu_pkg::GRP_LOGIC: res = logic_r;
      alu_pkg::GRP_MOVE:  res = move_r;
      alu_pkg::GRP_ARITH: res = arith_r;
      alu_pkg::GRP_DAA:   res = daa_r;
      default:            res = logic_r;
    endcase
  end

  // Shift by zero leaves every flag alone
  assign ld_mask = ((uop.op == alu_pkg::OP_SAL || uop.op == alu_pkg::OP_SAR) && cnt == 5'd0)
                   ? 6'd0 : uop.ld_flags;

  // Stage feeds zeros when idle, so an X op means a bad live uop
  always_comb begin
    op_known_a: assert final (!$isunknown(uop.op));
  end

endmodule

// ==== rtl/flags_reg.sv ====
`timescale 1ns/1ns

module flags_reg (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            flag_we,
  input  logic [5:0]      ld_mask,
  input  logic [5:0]      new_flags,
  input  logic            csr_flags_we,
  input  alu_pkg::flags_t csr_flags_wdata,
  output alu_pkg::flags_t cur_flags
);

  logic [5:0] arith_q;
  logic       df_q;
  logic [5:0] arith_d;

  // Only masked bits take the new value
  assign arith_d = (arith_q & ~ld_mask) | (new_flags & ld_mask);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      arith_q <= 6'd0;
      df_q    <= 1'b0;
    end else if (csr_flags_we) begin
      arith_q <= csr_flags_wdata[5:0];
      df_q    <= csr_flags_wdata.df;
    end else if (flag_we) begin
      arith_q <= arith_d;
    end
  end

  always_comb begin
    cur_flags.cf = arith_q[alu_pkg::FLAG_CF];
    cur_flags.pf = arith_q[alu_pkg::FLAG_PF];
    cur_flags.af = arith_q[alu_pkg::FLAG_AF];
    cur_flags.zf = arith_q[alu_pkg::FLAG_ZF];
    cur_flags.sf = arith_q[alu_pkg::FLAG_SF];
    cur_flags.of = arith_q[alu_pkg::FLAG_OF];
    cur_flags.df = df_q;
  end

  // Software writes flags only with the stage stopped
  no_dual_write_a: assert property (@(posedge clk) disable iff (!arst_n)
    !(flag_we && csr_flags_we));

endmodule

// ==== rtl/exec_stage.sv ====
`timescale 1ns/1ns

module exec_stage (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          enable,
  input  logic          uop_valid,
  output logic          uop_ready,
  input  alu_pkg::uop_t uop,
  output alu_pkg::uop_t alu_uop,
  input  alu_pkg::res_t alu_res,
  output logic          res_valid,
  input  logic          res_ready,
  output alu_pkg::res_t res,
  output logic          flag_we,
  input  logic          count_clr,
  output logic [31:0]   op_count
);

  logic accept;

  assign uop_ready = enable && (!res_valid || res_ready);
  assign accept    = uop_valid && uop_ready;
  assign flag_we   = accept;

  // Idle cycles show an all-zero uop (OR of zeros) to the ALU
  assign alu_uop = uop_valid ? uop : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
    end else if (accept) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res <= alu_res;
    end
  end

  // Retired ops, counted at the result handshake
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_count <= 32'd0;
    end else if (count_clr) begin
      op_count <= 32'd0;
    end else if (res_valid && res_ready) begin
      op_count <= op_count + 32'd1;
    end
  end

  res_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    res_valid && !res_ready |=> res_valid && $stable(res));

endmodule

// ==== rtl/alu_csr.sv ====
`timescale 1ns/1ns

module alu_csr (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [alu_pkg::CSR_AW-1:0] awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [31:0]                wdata,
  input  logic                       wvalid,
  output logic                       wready,
  output logic [1:0]                 bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [alu_pkg::CSR_AW-1:0] araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [31:0]                rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  logic                       rready,
  output logic                       enable,
  input  alu_pkg::flags_t            cur_flags,
  output logic                       csr_flags_we,
  output alu_pkg::flags_t            csr_flags_wdata,
  input  logic [31:0]                op_count,
  output logic                       count_clr
);

  logic wr_fire;
  logic rd_fire;

  // Address and data are taken on the same edge
  assign wready  = awready;
  assign wr_fire = awready && awvalid && wvalid;
  assign rd_fire = arready && arvalid;

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  assign csr_flags_we    = wr_fire && (awaddr == alu_pkg::CSR_FLAGS);
  assign csr_flags_wdata = alu_pkg::flags_t'(wdata[6:0]);
  assign count_clr       = wr_fire && (awaddr == alu_pkg::CSR_COUNT);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      awready <= 1'b0;
      bvalid  <= 1'b0;
      enable  <= 1'b0;
    end else begin
      awready <= awvalid && wvalid && !awready && !bvalid;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (wr_fire && awaddr == alu_pkg::CSR_CTRL) begin
        enable <= wdata[0];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      case (araddr)
        alu_pkg::CSR_CTRL:  rdata <= {31'd0, enable};
        alu_pkg::CSR_FLAGS: rdata <= {25'd0, cur_flags};
        alu_pkg::CSR_COUNT: rdata <= op_count;
        default:            rdata <= 32'd0;
      endcase
    end
  end

endmodule

// ==== rtl/exec_top.sv ====
`timescale 1ns/1ns

module exec_top (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       uop_valid,
  output logic                       uop_ready,
  input  alu_pkg::uop_t              uop,
  output logic                       res_valid,
  input  logic                       res_ready,
  output alu_pkg::res_t              res,
  input  logic [alu_pkg::CSR_AW-1:0] awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [31:0]                wdata,
  input  logic                       wvalid,
  output logic                       wready,
  output logic [1:0]                 bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [alu_pkg::CSR_AW-1:0] araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [31:0]                rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  logic                       rready
);

  alu_pkg::uop_t   alu_uop;
  alu_pkg::res_t   alu_res;
  alu_pkg::flags_t cur_flags;
  alu_pkg::flags_t csr_flags_wdata;
  logic [5:0]      ld_mask;
  logic            flag_we;
  logic            csr_flags_we;
  logic            enable;
  logic            count_clr;
  logic [31:0]     op_count;

  exec_stage u_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .enable    (enable),
    .uop_valid (uop_valid),
    .uop_ready (uop_ready),
    .uop       (uop),
    .alu_uop   (alu_uop),
    .alu_res   (alu_res),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res),
    .flag_we   (flag_we),
    .count_clr (count_clr),
    .op_count  (op_count)
  );

  alu1 u_alu (
    .uop       (alu_uop),
    .cur_flags (cur_flags),
    .res       (alu_res),
    .ld_mask   (ld_mask)
  );

  flags_reg u_flags (
    .clk             (clk),
    .arst_n          (arst_n),
    .flag_we         (flag_we),
    .ld_mask         (ld_mask),
    .new_flags       (alu_res.flags),
    .csr_flags_we    (csr_flags_we),
    .csr_flags_wdata (csr_flags_wdata),
    .cur_flags       (cur_flags)
  );

  alu_csr u_csr (
    .clk             (clk),
    .arst_n          (arst_n),
    .awaddr          (awaddr),
    .awvalid         (awvalid),
    .awready         (awready),
    .wdata           (wdata),
    .wvalid          (wvalid),
    .wready          (wready),
    .bresp           (bresp),
    .bvalid          (bvalid),
    .bready          (bready),
    .araddr          (araddr),
    .arvalid         (arvalid),
    .arready         (arready),
    .rdata           (rdata),
    .rresp           (rresp),
    .rvalid          (rvalid),
    .rready          (rready),
    .enable          (enable),
    .cur_flags       (cur_flags),
    .csr_flags_we    (csr_flags_we),
    .csr_flags_wdata (csr_flags_wdata),
    .op_count        (op_count),
    .count_clr       (count_clr)
  );

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset held for 8 cycles
  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

// ==== bench/exec_tb.sv ====
`timescale 1ns/1ns

module exec_tb;

  localparam int NCASES   = 24;
  localparam int NFIELDS  = 11;
  localparam int MAX_CYC  = NCASES * 20 + 200;

  logic          clk;
  logic          arst_n;
  logic          uop_valid;
  logic          uop_ready;
  alu_pkg::uop_t uop;
  logic          res_valid;
  logic          res_ready;
  alu_pkg::res_t res;
  logic [3:0]    awaddr;
  logic          awvalid;
  logic          awready;
  logic [31:0]   wdata;
  logic          wvalid;
  logic          wready;
  logic [1:0]    bresp;
  logic          bvalid;
  logic          bready;
  logic [3:0]    araddr;
  logic          arvalid;
  logic          arready;
  logic [31:0]   rdata;
  logic [1:0]    rresp;
  logic          rvalid;
  logic          rready;

  logic [31:0] cases [0:NCASES*NFIELDS-1];
  logic [15:0] lfsr_state;
  logic [15:0] lfsr_nxt;
  int          errors;
  int          xfers;
  int          tests_ok;
  int          tests_total;

  clk_gen u_clk (
    .clk    (clk),
    .arst_n (arst_n)
  );

  exec_top uut (
    .clk (clk), .arst_n (arst_n),
    .uop_valid (uop_valid), .uop_ready (uop_ready), .uop (uop),
    .res_valid (res_valid), .res_ready (res_ready), .res (res),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_total++;
    if (errors == errs_before) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      $display("%s: bad", name);
    end
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(posedge clk); while (!awready);
    assert (wready) else report_error($sformatf("wready %b with awready high", wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(posedge clk); while (!bvalid);
    assert (bresp == 2'b00) else report_error($sformatf("bresp %b", bresp));
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    do @(posedge clk); while (!rvalid);
    data = rdata;
    assert (rresp == 2'b00) else report_error($sformatf("rresp %b", rresp));
  endtask

  task automatic run_case(input int i);
    int            base;
    int            errs_before;
    alu_pkg::uop_t u;
    alu_pkg::res_t got;
    logic [31:0]   rd;
    base        = i * NFIELDS;
    errs_before = errors;
    // Preset column ff means leave the flags alone
    if (cases[base+10] != 32'h0000_00ff) begin
      axi_write(alu_pkg::CSR_CTRL, 32'd0);
      axi_write(alu_pkg::CSR_FLAGS, cases[base+10]);
      axi_write(alu_pkg::CSR_CTRL, 32'd1);
    end
    u.op        = alu_pkg::alu_op_e'(cases[base][3:0]);
    u.size      = alu_pkg::op_size_e'(cases[base+1][1:0]);
    u.elem_size = alu_pkg::op_size_e'(cases[base+2][1:0]);
    u.sr1       = cases[base+3];
    u.sr2       = cases[base+4];
    u.eax       = cases[base+5];
    u.ld_flags  = cases[base+6][5:0];
    @(posedge clk);
    uop       <= u;
    uop_valid <= 1'b1;
    do @(posedge clk); while (!uop_ready);
    uop_valid <= 1'b0;
    do @(posedge clk); while (!(res_valid && res_ready));
    got = res;
    assert (got.result == cases[base+7]) else
      report_error($sformatf("case %0d result %h, expected %h", i, got.result, cases[base+7]));
    assert (got.flags == cases[base+8][5:0]) else
      report_error($sformatf("case %0d flags %h, expected %h", i, got.flags,
                             cases[base+8][5:0]));
    axi_read(alu_pkg::CSR_FLAGS, rd);
    assert (rd[6:0] == cases[base+9][6:0]) else
      report_error($sformatf("case %0d cur_flags %h, expected %h", i, rd[6:0],
                             cases[base+9][6:0]));
    finish_test($sformatf("case %0d op %h", i, cases[base][3:0]), errs_before);
  endtask

  always @(posedge clk) begin
    lfsr_nxt = lfsr_next(lfsr_state);
    lfsr_state <= lfsr_nxt;
    res_ready  <= lfsr_nxt[0];
  end

  // Stalled result must block new uops
  always @(posedge clk) begin
    if (arst_n && res_valid && !res_ready) begin
      assert (!uop_ready) else report_error("uop_ready high while result stalled");
    end
    if (arst_n && res_valid && res_ready) begin
      xfers++;
    end
  end

  initial begin
    repeat (MAX_CYC) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", MAX_CYC);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    int          errs_before;
    errors      = 0;
    xfers       = 0;
    tests_ok    = 0;
    tests_total = 0;
    lfsr_state  = 16'd58006;
    uop_valid   = 1'b0;
    uop         = '0;
    res_ready   = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wvalid      = 1'b0;
    bready      = 1'b1;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b1;
    $readmemh("bench/exec_cases.txt", cases);
    wait (arst_n);
    @(posedge clk);

    errs_before = errors;
    uop_valid <= 1'b1;
    repeat (4) begin
      @(posedge clk);
      assert (!uop_ready) else report_error("uop_ready high with stage disabled");
    end
    uop_valid <= 1'b0;
    finish_test("disabled stage", errs_before);

    axi_write(alu_pkg::CSR_CTRL, 32'd1);
    for (int i = 0; i < NCASES; i++) begin
      run_case(i);
    end

    errs_before = errors;
    assert (xfers == NCASES) else
      report_error($sformatf("%0d results transferred, expected %0d", xfers, NCASES));
    axi_read(alu_pkg::CSR_COUNT, rd);
    assert (rd == 32'(NCASES)) else report_error($sformatf("COUNT %0d", rd));
    axi_write(alu_pkg::CSR_COUNT, 32'd0);
    axi_read(alu_pkg::CSR_COUNT, rd);
    assert (rd == 32'd0) else report_error($sformatf("COUNT after clear %0d", rd));
    finish_test("op count", errs_before);

    $display("summary: %0d of %0d ok, %0d errors", tests_ok, tests_total, errors);
    if (errors == 0 && tests_ok == tests_total) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== bench/exec_cases.txt ====
// op size elem_size sr1 sr2 eax ld_flags exp_result exp_flags exp_cur_flags preset
// preset: value written to CSR FLAGS before the case, ff for none
0 0 0 00000012 00000021 00000000 3f 00000033 02 02 ff
1 1 0 0000f0f0 00008f0f 00000000 3f 00008000 12 12 ff
1 2 0 ff00ff00 00ff00ff 00000000 3f 00000000 0a 0a ff
2 0 0 00000041 00000001 00000000 3f 00000082 32 32 ff
2 2 0 00000005 00000000 00000000 3f 00000005 02 32 ff
3 1 0 00008004 00000002 00000000 3f ffffe001 10 10 ff
4 2 0 80000000 00000000 00000000 3f 80000000 12 12 ff
5 0 0 00000000 00000100 00000000 00 00000100 0a 12 ff
6 2 0 12345678 00000009 00000000 3f 00000000 0a 0a ff
7 1 0 0000ff00 00000000 00000000 3f ffff00ff 02 02 ff
9 0 0 0000007f 00000001 00000000 3f 00000080 34 34 ff
9 1 0 0000ffff 00000001 00000000 3f 00010000 0f 0f ff
8 0 0 0000000f 00000000 00000000 3e 00000010 04 05 ff
b 2 0 00000007 00000000 00000005 3f 00000007 15 15 ff
b 0 0 00000001 00000000 00000080 3f 00000001 24 24 ff
b 1 0 00001234 00000000 00001234 3f 00001234 0a 0a ff
a 2 0 00001000 00000000 00000000 00 00001001 00 00 00
a 2 1 00001000 00000000 00000000 00 00000ffe 00 40 40
a 2 2 00001000 00000000 00000000 00 00000ffc 00 40 ff
c 0 0 00000000 00000000 0000002f 3f 00000035 06 06 00
c 0 0 00000000 00000000 abcd0012 3f abcd0018 06 06 ff
c 0 0 00000000 00000000 00000034 3f 00000094 11 11 01
c 0 0 00000000 00000000 0000009a 3f 00000000 0f 0f ff
3 0 0 00000080 00000020 00000000 3f ffffff80 10 0f ff

// ==== filelist.f ====
rtl/alu_pkg.sv
rtl/alu1.sv
rtl/flags_reg.sv
rtl/exec_stage.sv
rtl/alu_csr.sv
rtl/exec_top.sv
bench/clk_gen.sv
bench/exec_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = exec_tb
FILELIST = filelist.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
